//--- tmr_pkg.sv
// TMR register file shared definitions

package tmr_pkg;

    // Redundancy level of every stored word
    localparam int NUM_COPIES = 3;

    // Width of the scrub repair counter
    localparam int FIX_CNT_W = 16;

    // Scrubber sequence
    // IDLE waits for the interval timer, READ samples the voted word,
    // FIX writes the voted word back to all copies
    typedef enum logic [1:0] {
        SCRUB_IDLE = 2'd0,
        SCRUB_READ = 2'd1,
        SCRUB_FIX  = 2'd2
    } scrub_state_e;

endpackage

//--- seu_reg_file.sv
// Single copy of the register file

`timescale 1ns/1ns

module seu_reg_file #(
    parameter int DATA_W = 32,
    parameter int N_REGS = 16
) (
    input  logic                      s_c_i,
    input  logic                      rst_i,
    input  logic                      we_i,
    input  logic [$clog2(N_REGS)-1:0] wa_i,
    input  logic [DATA_W-1:0]         d_i,
    input  logic                      inj_en_i,
    input  logic [$clog2(N_REGS)-1:0] inj_addr_i,
    input  logic [DATA_W-1:0]         inj_mask_i,
    input  logic [$clog2(N_REGS)-1:0] ra_i,
    output logic [DATA_W-1:0]         q_o,
    input  logic [$clog2(N_REGS)-1:0] sa_i,
    output logic [DATA_W-1:0]         sq_o
);
    localparam int AW = $clog2(N_REGS);

    logic [DATA_W-1:0] mem [N_REGS];

    for (genvar i = 0; i < N_REGS; i++) begin : g_word
        logic              wr_hit;
        logic              inj_hit;
        logic [DATA_W-1:0] next_val;
        logic [DATA_W-1:0] flip;

        assign wr_hit   = we_i && (wa_i == AW'(i));
        assign inj_hit  = inj_en_i && (inj_addr_i == AW'(i));
        assign next_val = wr_hit ? d_i : mem[i];    // Upset lands on the value being stored
        assign flip     = inj_hit ? inj_mask_i : '0;

        always_ff @(posedge s_c_i) begin
            if (rst_i) begin
                mem[i] <= '0;
            end else if (wr_hit || inj_hit) begin
                mem[i] <= next_val ^ flip;
            end
        end
    end

    // User read port
    assign q_o  = mem[ra_i];

    // Scrubber read port
    assign sq_o = mem[sa_i];

endmodule

//--- tmr_voter.sv
// Three-way majority voter

`timescale 1ns/1ns

module tmr_voter import tmr_pkg::*; #(
    parameter int DATA_W = 32
) (
    input  logic [DATA_W-1:0] a_i,
    input  logic [DATA_W-1:0] b_i,
    input  logic [DATA_W-1:0] c_i,
    output logic [DATA_W-1:0] q_o,
    output logic              err_o
);
    logic [DATA_W-1:0] words [NUM_COPIES];
    logic [DATA_W-1:0] diff;

    assign words[0] = a_i;
    assign words[1] = b_i;
    assign words[2] = c_i;

    // Two of three per bit
    assign q_o = (a_i & b_i) | (a_i & c_i) | (b_i & c_i);

    // Compare each copy with its neighbour around the ring
    always_comb begin
        diff = '0;
        for (int i = 0; i < NUM_COPIES; i++) begin
            diff |= words[i] ^ words[(i + 1) % NUM_COPIES];
        end
    end

    assign err_o = |diff;

endmodule

//--- scrub_timer.sv
// Scrub interval timer and address pointer

`timescale 1ns/1ns

module scrub_timer #(
    parameter int N_REGS       = 16,
    parameter int SCRUB_PERIOD = 8
) (
    input  logic                      s_c_i,
    input  logic                      rst_i,
    input  logic                      run_i,
    input  logic                      advance_i,
    output logic                      step_o,
    output logic [$clog2(N_REGS)-1:0] scrub_addr_o
);
    localparam int AW    = $clog2(N_REGS);
    localparam int CNT_W = $clog2(SCRUB_PERIOD + 1);

    logic [CNT_W-1:0] cnt_q;
    logic [AW-1:0]    addr_q;

    // Fires once SCRUB_PERIOD idle cycles have gone by
    assign step_o = run_i && (cnt_q == CNT_W'(SCRUB_PERIOD));

    always_ff @(posedge s_c_i) begin
        if (rst_i) begin
            cnt_q <= '0;
        end else if (!run_i || step_o) begin
            cnt_q <= '0;                // Restart on every return to idle
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // Power of two depth, so the pointer wraps by itself
    always_ff @(posedge s_c_i) begin
        if (rst_i) begin
            addr_q <= '0;
        end else if (advance_i) begin
            addr_q <= addr_q + 1'b1;
        end
    end

    assign scrub_addr_o = addr_q;

endmodule

//--- scrub_fsm.sv
// Scrubber state machine and repair counter

`timescale 1ns/1ns

module scrub_fsm import tmr_pkg::*; #(
    parameter int DATA_W = 32,
    parameter int N_REGS = 16
) (
    input  logic                      s_c_i,
    input  logic                      rst_i,
    input  logic                      step_i,
    input  logic                      wr_en_i,
    input  logic [$clog2(N_REGS)-1:0] wr_addr_i,
    input  logic [$clog2(N_REGS)-1:0] scrub_addr_i,
    input  logic [DATA_W-1:0]         scrub_word_i,
    input  logic                      scrub_err_i,
    output logic                      run_o,
    output logic                      advance_o,
    output logic                      fix_en_o,
    output logic [$clog2(N_REGS)-1:0] fix_addr_o,
    output logic [DATA_W-1:0]         fix_data_o,
    output logic                      busy_o,
    output logic [FIX_CNT_W-1:0]      fixes_o
);
    localparam int AW = $clog2(N_REGS);

    scrub_state_e         state_q;
    scrub_state_e         state_d;
    logic [DATA_W-1:0]    word_q;
    logic [AW-1:0]        addr_q;
    logic [FIX_CNT_W-1:0] fixes_q;
    logic                 hit_read;
    logic                 hit_fix;

    // User write to the word under scrub makes the vote stale
    assign hit_read = wr_en_i && (wr_addr_i == scrub_addr_i);
    assign hit_fix  = wr_en_i && (wr_addr_i == addr_q);

    always_comb begin
        state_d   = state_q;
        advance_o = 1'b0;
        case (state_q)
            SCRUB_IDLE: begin
                if (step_i) state_d = SCRUB_READ;
            end
            SCRUB_READ: begin
                if (!scrub_err_i || hit_read) begin
                    state_d   = SCRUB_IDLE;   // Clean word or overwritten
                    advance_o = 1'b1;
                end else begin
                    state_d   = SCRUB_FIX;
                end
            end
            SCRUB_FIX: begin
                if (hit_fix || !wr_en_i) begin  // Dropped or written back
                    state_d   = SCRUB_IDLE;
                    advance_o = 1'b1;
                end
            end
            default: state_d = SCRUB_IDLE;
        endcase
    end

    always_ff @(posedge s_c_i) begin
        if (rst_i) begin
            state_q <= SCRUB_IDLE;
            fixes_q <= '0;
        end else begin
            state_q <= state_d;
            if (fix_en_o && (fixes_q != '1)) fixes_q <= fixes_q + 1'b1;   // Saturates
        end
    end

    // Voted word and its address, held for the write back
    always_ff @(posedge s_c_i) begin
        if (state_q == SCRUB_READ) begin
            word_q <= scrub_word_i;
            addr_q <= scrub_addr_i;
        end
    end

    // User writes keep priority over the repair
    assign fix_en_o   = (state_q == SCRUB_FIX) && !wr_en_i;
    assign fix_addr_o = addr_q;
    assign fix_data_o = word_q;
    assign run_o      = (state_q == SCRUB_IDLE);
    assign busy_o     = (state_q != SCRUB_IDLE);
    assign fixes_o    = fixes_q;

endmodule

//--- tmr_reg_file.sv
// TMR register file with scrubbing

`timescale 1ns/1ns

module tmr_reg_file import tmr_pkg::*; #(
    parameter int DATA_W       = 32,
    parameter int N_REGS       = 16,
    parameter int SCRUB_PERIOD = 8
) (
    input  logic                          s_c_i,
    input  logic                          rst_i,
    input  logic                          wr_en_i,
    input  logic [$clog2(N_REGS)-1:0]     wr_addr_i,
    input  logic [DATA_W-1:0]             wr_data_i,
    input  logic [$clog2(N_REGS)-1:0]     rd_addr_i,
    output logic [DATA_W-1:0]             rd_data_o,
    output logic                          rd_err_o,
    input  logic                          inj_en_i,
    input  logic [$clog2(NUM_COPIES)-1:0] inj_copy_i,
    input  logic [$clog2(N_REGS)-1:0]     inj_addr_i,
    input  logic [DATA_W-1:0]             inj_mask_i,
    output logic [FIX_CNT_W-1:0]          scrub_fixes_o,
    output logic                          scrub_busy_o
);
    localparam int AW    = $clog2(N_REGS);
    localparam int CPY_W = $clog2(NUM_COPIES);

    logic [DATA_W-1:0] rd_q [NUM_COPIES];   // User read of each copy
    logic [DATA_W-1:0] sc_q [NUM_COPIES];   // Scrub read of each copy
    logic              we;
    logic [AW-1:0]     wa;
    logic [DATA_W-1:0] wd;
    logic              fix_en;
    logic [AW-1:0]     fix_addr;
    logic [DATA_W-1:0] fix_data;
    logic [AW-1:0]     scrub_addr;
    logic [DATA_W-1:0] scrub_word;
    logic              scrub_err;
    logic              step;
    logic              run;
    logic              advance;

    // Shared write port, user first
    assign we = wr_en_i | fix_en;
    assign wa = wr_en_i ? wr_addr_i : fix_addr;
    assign wd = wr_en_i ? wr_data_i : fix_data;

    for (genvar i = 0; i < NUM_COPIES; i++) begin : g_copy
        logic inj_hit;

        assign inj_hit = inj_en_i && (inj_copy_i == CPY_W'(i));

        seu_reg_file #(.DATA_W(DATA_W), .N_REGS(N_REGS)) u_copy (
            .s_c_i      (s_c_i),
            .rst_i      (rst_i),
            .we_i       (we),
            .wa_i       (wa),
            .d_i        (wd),
            .inj_en_i   (inj_hit),
            .inj_addr_i (inj_addr_i),
            .inj_mask_i (inj_mask_i),
            .ra_i       (rd_addr_i),
            .q_o        (rd_q[i]),
            .sa_i       (scrub_addr),
            .sq_o       (sc_q[i])
        );
    end

    tmr_voter #(.DATA_W(DATA_W)) u_rd_voter (
        .a_i(rd_q[0]), .b_i(rd_q[1]), .c_i(rd_q[2]), .q_o(rd_data_o), .err_o(rd_err_o)
    );

    tmr_voter #(.DATA_W(DATA_W)) u_scrub_voter (
        .a_i(sc_q[0]), .b_i(sc_q[1]), .c_i(sc_q[2]), .q_o(scrub_word), .err_o(scrub_err)
    );

    scrub_timer #(.N_REGS(N_REGS), .SCRUB_PERIOD(SCRUB_PERIOD)) u_timer (
        .s_c_i        (s_c_i),
        .rst_i        (rst_i),
        .run_i        (run),
        .advance_i    (advance),
        .step_o       (step),
        .scrub_addr_o (scrub_addr)
    );

    scrub_fsm #(.DATA_W(DATA_W), .N_REGS(N_REGS)) u_fsm (
        .s_c_i        (s_c_i),
        .rst_i        (rst_i),
        .step_i       (step),
        .wr_en_i      (wr_en_i),
        .wr_addr_i    (wr_addr_i),
        .scrub_addr_i (scrub_addr),
        .scrub_word_i (scrub_word),
        .scrub_err_i  (scrub_err),
        .run_o        (run),
        .advance_o    (advance),
        .fix_en_o     (fix_en),
        .fix_addr_o   (fix_addr),
        .fix_data_o   (fix_data),
        .busy_o       (scrub_busy_o),
        .fixes_o      (scrub_fixes_o)
    );

endmodule

//--- tmr_reg_file_sva.sv
// TMR register file assertions

`timescale 1ns/1ns

module tmr_reg_file_sva #(
    parameter int DATA_W = 32
) (
    input logic              s_c_i,
    input logic              rst_i,
    input logic              wr_en_i,
    input logic              fix_en,
    input logic [DATA_W-1:0] fix_data,
    input logic [DATA_W-1:0] scrub_word,
    input logic              scrub_busy_o
);
    logic              busy_q;
    logic [DATA_W-1:0] read_word_q;   // Vote seen in the READ cycle

    // READ is always the first busy cycle of a step
    always_ff @(posedge s_c_i) begin
        if (rst_i) begin
            busy_q <= 1'b0;
        end else begin
            busy_q <= scrub_busy_o;
            if (scrub_busy_o && !busy_q) read_word_q <= scrub_word;
        end
    end

    no_fix_on_write: assert property (@(posedge s_c_i) disable iff (rst_i)
        !(fix_en && wr_en_i))
        else $error("Scrub repair issued in the same cycle as a user write");

    idle_after_reset: assert property (@(posedge s_c_i) rst_i |=> !scrub_busy_o)
        else $error("Scrubber busy right after reset");

    fix_uses_read_word: assert property (@(posedge s_c_i) disable iff (rst_i)
        fix_en |-> (fix_data == read_word_q))
        else $error("Scrub repair data differs from the word voted in READ");

endmodule

bind tmr_reg_file tmr_reg_file_sva #(.DATA_W(DATA_W)) u_sva (
    .s_c_i        (s_c_i),
    .rst_i        (rst_i),
    .wr_en_i      (wr_en_i),
    .fix_en       (fix_en),
    .fix_data     (fix_data),
    .scrub_word   (scrub_word),
    .scrub_busy_o (scrub_busy_o)
);

//--- tb_tmr_reg_file.sv
// TMR register file testbench

`timescale 1ns/1ns

module tb_tmr_reg_file
    import tmr_pkg::*;
();
    localparam int DATA_W       = 32;
    localparam int N_REGS       = 16;
    localparam int SCRUB_PERIOD = 8;
    localparam int AW           = $clog2(N_REGS);
    localparam int SWEEP        = N_REGS * (SCRUB_PERIOD + 3);   // Worst case full sweep
    localparam int N_P2         = 160;
    localparam int N_P3         = 30;
    localparam int N_P4         = 30;
    localparam int N_P5         = 200;
    localparam int RUN_LIMIT    = 8 + N_REGS + N_P2 + 3 * N_P3 + 3 * N_P4 + N_P5
                                  + N_REGS + 2 * SWEEP;

    logic                 s_c_i = 1'b0;
    logic                 rst_i;
    logic                 wr_en_i;
    logic [AW-1:0]        wr_addr_i;
    logic [DATA_W-1:0]    wr_data_i;
    logic [AW-1:0]        rd_addr_i;
    logic [DATA_W-1:0]    rd_data_o;
    logic                 rd_err_o;
    logic                 inj_en_i;
    logic [1:0]           inj_copy_i;
    logic [AW-1:0]        inj_addr_i;
    logic [DATA_W-1:0]    inj_mask_i;
    logic [FIX_CNT_W-1:0] scrub_fixes_o;
    logic                 scrub_busy_o;

    logic [DATA_W-1:0] model [NUM_COPIES][N_REGS];   // Reference copies
    logic [DATA_W-1:0] latch_word;                   // Vote taken in the scrub READ cycle
    int                latch_addr;                   // Address of that vote
    int                errors;
    int                cycles;

    tmr_reg_file UUT (.*);

    always #2 s_c_i = ~s_c_i;

    always @(posedge s_c_i) begin
        cycles++;
        if (cycles > RUN_LIMIT) begin
            $display("Run did not finish within %0d cycles", RUN_LIMIT);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    function automatic logic [DATA_W-1:0] model_vote(input int a);
        logic [DATA_W-1:0] x;
        logic [DATA_W-1:0] y;
        logic [DATA_W-1:0] z;
        x = model[0][a];
        y = model[1][a];
        z = model[2][a];
        return (x & y) | (y & z) | (x & z);   // Each bit set in at least two copies
    endfunction

    function automatic logic model_split(input int a);
        return (model[0][a] != model[1][a]) || (model[1][a] != model[2][a]);
    endfunction

    function automatic int count_split();
        int n;
        n = 0;
        for (int i = 0; i < N_REGS; i++) n += int'(model_split(i));
        return n;
    endfunction

    function automatic int rand_addr();
        return int'($urandom % N_REGS);
    endfunction

    function automatic logic [DATA_W-1:0] rand_mask();
        logic [DATA_W-1:0] m;
        m = $urandom;
        if (m == '0) m = 1;   // An empty mask would not upset anything
        return m;
    endfunction

    task automatic check_read(input string name, input int a);
        logic [DATA_W-1:0] exp_d;
        logic              exp_e;
        exp_d = model_vote(a);
        exp_e = model_split(a);
        assert (rd_data_o === exp_d) else begin
            errors++;
            $display("error %s addr %0d data: expected %h, actual %h", name, a, exp_d, rd_data_o);
        end
        assert (rd_err_o === exp_e) else begin
            errors++;
            $display("error %s addr %0d err: expected %b, actual %b", name, a, exp_e, rd_err_o);
        end
    endtask

    // One clock cycle, entered and left on a falling edge
    task automatic run_cycle(input logic we, input int wa, input logic [DATA_W-1:0] wd,
                             input logic inj, input int cp, input int ia,
                             input logic [DATA_W-1:0] mask, input int ra, input string name);
        logic              fix_now;
        int                fix_a;
        logic [DATA_W-1:0] fix_word;
        wr_en_i    = we;
        wr_addr_i  = AW'(wa);
        wr_data_i  = wd;
        inj_en_i   = inj;
        inj_copy_i = 2'(cp);
        inj_addr_i = AW'(ia);
        inj_mask_i = mask;
        rd_addr_i  = AW'(ra);
        #1;
        check_read(name, ra);
        fix_now  = UUT.fix_en;             // Repair timing taken from the scrubber
        fix_a    = latch_addr;
        fix_word = latch_word;
        if (UUT.u_fsm.state_q == SCRUB_READ) begin
            latch_word = model_vote(int'(UUT.scrub_addr));
            latch_addr = int'(UUT.scrub_addr);
        end
        for (int c = 0; c < NUM_COPIES; c++) begin
            if (we) model[c][wa] = wd;
            else if (fix_now) model[c][fix_a] = fix_word;
        end
        if (inj) model[cp][ia] = model[cp][ia] ^ mask;   // Upset lands on the next value
        @(negedge s_c_i);
    endtask

    initial begin
        logic [DATA_W-1:0] mask;
        int                a;
        int                c1;
        int                c2;
        int                n_split;
        logic [FIX_CNT_W-1:0] base_fixes;
        void'($urandom(32'hd95e));
        errors = 0;
        cycles = 0;
        latch_word = '0;
        latch_addr = 0;
        rst_i = 1'b1;
        wr_en_i = 1'b0;
        wr_addr_i = '0;
        wr_data_i = '0;
        rd_addr_i = '0;
        inj_en_i = 1'b0;
        inj_copy_i = '0;
        inj_addr_i = '0;
        inj_mask_i = '0;
        for (int c = 0; c < NUM_COPIES; c++)
            for (int i = 0; i < N_REGS; i++) model[c][i] = '0;
        repeat (8) @(posedge s_c_i);
        @(negedge s_c_i);
        rst_i = 1'b0;

        for (int i = 0; i < N_REGS; i++) run_cycle(0, 0, 0, 0, 0, 0, 0, i, "reset_read");
        assert (scrub_fixes_o == '0) else begin
            errors++;
            $display("error reset_fixes: expected 0, actual %0d", scrub_fixes_o);
        end

        // Clean writes and reads, nothing for the scrubber to do
        for (int t = 0; t < N_P2; t++)
            run_cycle($urandom % 2, rand_addr(), $urandom, 0, 0, 0, 0, rand_addr(), "write_read");

        for (int t = 0; t < N_P3; t++) begin
            a = rand_addr();
            c1 = int'($urandom % NUM_COPIES);
            mask = rand_mask();
            run_cycle(0, 0, 0, 1, c1, a, mask, a, "single_inject");
            run_cycle(1, a, $urandom, 0, 0, 0, 0, a, "single_inject");
            run_cycle(0, 0, 0, 0, 0, 0, 0, a, "write_clears");
        end

        // Same mask into two different copies
        for (int t = 0; t < N_P4; t++) begin
            a = rand_addr();
            c1 = int'($urandom % NUM_COPIES);
            c2 = (c1 + 1 + int'($urandom % 2)) % NUM_COPIES;
            mask = rand_mask();
            run_cycle(0, 0, 0, 1, c1, a, mask, a, "double_inject");
            run_cycle(0, 0, 0, 1, c2, a, mask, a, "double_inject");
            run_cycle(0, 0, 0, 0, 0, 0, 0, a, "double_inject");
        end

        for (int t = 0; t < N_P5; t++)
            run_cycle(($urandom % 3) == 0, rand_addr(), $urandom, ($urandom % 4) == 0,
                      int'($urandom % NUM_COPIES), rand_addr(), rand_mask(), rand_addr(), "mixed");

        while (scrub_busy_o) run_cycle(0, 0, 0, 0, 0, 0, 0, 0, "quiet_settle");
        n_split = count_split();
        base_fixes = scrub_fixes_o;
        repeat (SWEEP) run_cycle(0, 0, 0, 0, 0, 0, 0, rand_addr(), "quiet_sweep");
        for (int i = 0; i < N_REGS; i++) run_cycle(0, 0, 0, 0, 0, 0, 0, i, "after_sweep");
        assert (count_split() == 0) else begin
            errors++;
            $display("error sweep_clean: expected 0, actual %0d", count_split());
        end
        assert (int'(scrub_fixes_o - base_fixes) == n_split) else begin
            errors++;
            $display("error sweep_fixes: expected %0d, actual %0d", n_split,
                     int'(scrub_fixes_o - base_fixes));
        end

        $display("Checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- vlog.f
tmr_pkg.sv
seu_reg_file.sv
tmr_voter.sv
scrub_timer.sv
scrub_fsm.sv
tmr_reg_file.sv
tmr_reg_file_sva.sv
tb_tmr_reg_file.sv

//--- Makefile
# Verilator build and run for the TMR register file

TOP = tb_tmr_reg_file
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP) -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee $(LOG)
	@if grep -qF "*** TEST FAILED ***" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -qF "*** TEST PASSED ***" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
